// File: Bender.yml
package:
  name: lpif_adapter

sources:
  - common/lpif_pkg.sv
  - rtl/lpif_link_ctl.sv
  - lsm/lpif_lsm.sv
  - txrx/lpif_tx.sv
  - txrx/lpif_rx.sv
  - rtl/lpif_adapter.sv
  - target: simulation
    files:
      - verification/lpif_checker.sv
      - verification/tb_lpif_adapter.sv

// File: common/lpif_pkg.sv
/*
 * Shared constants, LPIF link states and packed payload types for the
 * reduced LPIF-to-AIB adapter. Every block reaches these by scoped names.
 */

package lpif_pkg;

  ////////////////////////////////////////////////////////////
  // AIB and LPIF sizing
  ////////////////////////////////////////////////////////////

  localparam int AIB_LANES         = 2;
  localparam int AIB_BITS_PER_LANE = 40;
  localparam int AIB_WIDTH         = AIB_LANES * AIB_BITS_PER_LANE; // 80 bits on the wire

  localparam int LPIF_DATA_BYTES   = 8;
  localparam int STREAM_WIDTH      = 8;
  localparam int FLIT_WIDTH        = STREAM_WIDTH + LPIF_DATA_BYTES * 8;
  localparam int AIB_RSVD_BITS     = AIB_WIDTH - 1 - FLIT_WIDTH; // Pad between valid and flit

  ////////////////////////////////////////////////////////////
  // Buffering and link settle
  ////////////////////////////////////////////////////////////

  localparam int TX_FIFO_DEPTH      = 4;
  localparam int TX_PTR_WIDTH       = $clog2(TX_FIFO_DEPTH);
  localparam int TX_CNT_WIDTH       = $clog2(TX_FIFO_DEPTH + 1);
  localparam logic [TX_PTR_WIDTH-1:0] TX_PTR_LAST = TX_PTR_WIDTH'(TX_FIFO_DEPTH - 1);
  localparam logic [TX_CNT_WIDTH-1:0] TX_CNT_FULL = TX_CNT_WIDTH'(TX_FIFO_DEPTH);

  localparam int LINK_SETTLE_CYCLES = 8;
  localparam int SETTLE_CNT_WIDTH   = $clog2(LINK_SETTLE_CYCLES);
  localparam logic [SETTLE_CNT_WIDTH-1:0] SETTLE_LAST =
    SETTLE_CNT_WIDTH'(LINK_SETTLE_CYCLES - 1);

  // LPIF state encoding, subset kept by this adapter
  typedef enum logic [3:0] {
    ST_RESET     = 4'd0,
    ST_ACTIVE    = 4'd1,
    ST_LINKERROR = 4'd10,
    ST_RETRAIN   = 4'd11
  } lpif_state_e;

  // One link layer flit
  typedef struct packed {
    logic [STREAM_WIDTH-1:0]      stream;
    logic [LPIF_DATA_BYTES*8-1:0] data;
  } lpif_flit_t;

  // Word format on data_in_f and dout
  typedef struct packed {
    logic                     valid;
    logic [AIB_RSVD_BITS-1:0] rsvd;  // Always zero on transmit
    lpif_flit_t               flit;
  } aib_word_t;

  // Link control to state machine
  typedef struct packed {
    logic link_up;
    logic phy_err;
  } link_status_t;

endpackage

// File: files.f
common/lpif_pkg.sv
rtl/lpif_link_ctl.sv
lsm/lpif_lsm.sv
txrx/lpif_tx.sv
txrx/lpif_rx.sv
rtl/lpif_adapter.sv
verification/lpif_checker.sv
verification/tb_lpif_adapter.sv

// File: lsm/lpif_lsm.sv
/*
 * LPIF link state machine with Reset, Active, Retrain and LinkError.
 * Reports the current state on pl_state_sts and raises pl_lnk_up while
 * Active, which also enables the transmit and receive paths.
 */

`timescale 1ns/10ps

module lpif_lsm (
  input  logic                   lclk,
  input  logic                   arst_n,
  input  lpif_pkg::lpif_state_e  lp_state_req,
  input  logic                   lp_linkerror,
  input  lpif_pkg::link_status_t link_sts,
  output lpif_pkg::lpif_state_e  pl_state_sts,
  output logic                   pl_lnk_up
);

  lpif_pkg::lpif_state_e state_nxt;
  logic                  req_active;
  logic                  req_retrain;
  logic                  req_reset;

  assign req_active  = (lp_state_req == lpif_pkg::ST_ACTIVE);
  assign req_retrain = (lp_state_req == lpif_pkg::ST_RETRAIN);
  assign req_reset   = (lp_state_req == lpif_pkg::ST_RESET);

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    state_nxt = pl_state_sts;
    case (pl_state_sts)
      lpif_pkg::ST_RESET:
      begin
        if (link_sts.link_up && req_active)
        begin
          state_nxt = lpif_pkg::ST_ACTIVE;
        end
      end
      lpif_pkg::ST_ACTIVE:
      begin
        // Errors win over retrain
        if (link_sts.phy_err || lp_linkerror)
        begin
          state_nxt = lpif_pkg::ST_LINKERROR;
        end
        else if (!link_sts.link_up || req_retrain)
        begin
          state_nxt = lpif_pkg::ST_RETRAIN;
        end
      end
      lpif_pkg::ST_RETRAIN:
      begin
        if (link_sts.link_up && req_active)
        begin
          state_nxt = lpif_pkg::ST_ACTIVE;
        end
      end
      lpif_pkg::ST_LINKERROR:
      begin
        if (req_reset)
        begin
          state_nxt = lpif_pkg::ST_RESET;  // Only way out of error
        end
      end
      default:
      begin
        state_nxt = lpif_pkg::ST_RESET;
      end
    endcase
  end

  always_ff @(posedge lclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pl_state_sts <= lpif_pkg::ST_RESET;
    end
    else
    begin
      pl_state_sts <= state_nxt;
    end
  end

  assign pl_lnk_up = (pl_state_sts == lpif_pkg::ST_ACTIVE);

endmodule

// File: rtl/lpif_adapter.sv
/*
 * Top level of the reduced LPIF-to-AIB adapter. Joins link bring-up
 * control, the LPIF state machine and the transmit and receive paths.
 * Single clock lclk, asynchronous active low reset arst_n.
 */

`timescale 1ns/10ps

module lpif_adapter (
  input  logic                                   lclk,
  input  logic                                   arst_n,

  // LPIF downstream
  input  logic                                   lp_irdy,
  input  logic                                   lp_valid,
  input  logic [lpif_pkg::LPIF_DATA_BYTES*8-1:0] lp_data,
  input  logic [lpif_pkg::STREAM_WIDTH-1:0]      lp_stream,
  output logic                                   pl_trdy,

  // LPIF upstream
  output logic                                   pl_valid,
  output logic [lpif_pkg::LPIF_DATA_BYTES*8-1:0] pl_data,
  output logic [lpif_pkg::STREAM_WIDTH-1:0]      pl_stream,

  // LPIF state
  input  lpif_pkg::lpif_state_e                  lp_state_req,
  input  logic                                   lp_linkerror,
  output lpif_pkg::lpif_state_e                  pl_state_sts,
  output logic                                   pl_lnk_up,

  // AIB side
  input  logic                                   i_conf_done,
  input  logic                                   fs_mac_rdy,
  input  logic [lpif_pkg::AIB_LANES-1:0]         tx_transfer_en,
  input  logic [lpif_pkg::AIB_LANES-1:0]         rx_transfer_en,
  input  logic                                   align_done,
  input  logic                                   align_err,
  input  lpif_pkg::aib_word_t                    dout,
  input  logic                                   lpbk_en,
  output logic                                   ns_mac_rdy,
  output logic                                   tx_online,
  output logic                                   rx_online,
  output lpif_pkg::aib_word_t                    data_in_f
);

  lpif_pkg::link_status_t link_sts;
  lpif_pkg::lpif_flit_t   lp_flit;
  lpif_pkg::lpif_flit_t   rx_flit;

  assign lp_flit.stream = lp_stream;
  assign lp_flit.data   = lp_data;

  assign pl_data   = rx_flit.data;
  assign pl_stream = rx_flit.stream;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  lpif_link_ctl u_link_ctl (
    .lclk           (lclk),
    .arst_n         (arst_n),
    .i_conf_done    (i_conf_done),
    .fs_mac_rdy     (fs_mac_rdy),
    .tx_transfer_en (tx_transfer_en),
    .rx_transfer_en (rx_transfer_en),
    .align_done     (align_done),
    .align_err      (align_err),
    .ns_mac_rdy     (ns_mac_rdy),
    .tx_online      (tx_online),
    .rx_online      (rx_online),
    .link_sts       (link_sts)
  );

  lpif_lsm u_lsm (
    .lclk         (lclk),
    .arst_n       (arst_n),
    .lp_state_req (lp_state_req),
    .lp_linkerror (lp_linkerror),
    .link_sts     (link_sts),
    .pl_state_sts (pl_state_sts),
    .pl_lnk_up    (pl_lnk_up)
  );

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  lpif_tx u_tx (
    .lclk      (lclk),
    .arst_n    (arst_n),
    .tx_enable (pl_lnk_up),  // Drains only while Active
    .lp_irdy   (lp_irdy),
    .lp_valid  (lp_valid),
    .lp_flit   (lp_flit),
    .pl_trdy   (pl_trdy),
    .data_in_f (data_in_f)
  );

  lpif_rx u_rx (
    .lclk      (lclk),
    .arst_n    (arst_n),
    .rx_enable (pl_lnk_up),
    .lpbk_en   (lpbk_en),
    .dout      (dout),
    .tx_word   (data_in_f),  // Loopback source
    .pl_valid  (pl_valid),
    .pl_flit   (rx_flit)
  );

endmodule

// File: rtl/lpif_link_ctl.sv
/*
 * AIB bring-up control. Raises ns_mac_rdy once configuration is done,
 * then waits for a run of good cycles on the far-side ready, transfer
 * enables and alignment before reporting link-up to the state machine.
 */

`timescale 1ns/10ps

module lpif_link_ctl (
  input  logic                           lclk,
  input  logic                           arst_n,
  input  logic                           i_conf_done,
  input  logic                           fs_mac_rdy,
  input  logic [lpif_pkg::AIB_LANES-1:0] tx_transfer_en,
  input  logic [lpif_pkg::AIB_LANES-1:0] rx_transfer_en,
  input  logic                           align_done,
  input  logic                           align_err,
  output logic                           ns_mac_rdy,
  output logic                           tx_online,
  output logic                           rx_online,
  output lpif_pkg::link_status_t         link_sts
);

  logic                                  link_good;
  logic [lpif_pkg::SETTLE_CNT_WIDTH-1:0] settle_cnt;

  // Every bring-up condition this cycle
  assign link_good = ns_mac_rdy & fs_mac_rdy & (&tx_transfer_en) & (&rx_transfer_en) &
                     align_done;

  always_ff @(posedge lclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ns_mac_rdy <= 1'b0;
    end
    else if (i_conf_done)
    begin
      ns_mac_rdy <= 1'b1;  // Sticky
    end
  end

  // Settle counter, saturates once link is up
  always_ff @(posedge lclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      settle_cnt       <= '0;
      link_sts.link_up <= 1'b0;
    end
    else if (!link_good)
    begin
      settle_cnt       <= '0;
      link_sts.link_up <= 1'b0;
    end
    else if (settle_cnt == lpif_pkg::SETTLE_LAST)
    begin
      link_sts.link_up <= 1'b1;
    end
    else
    begin
      settle_cnt <= settle_cnt + 1'b1;
    end
  end

  always_ff @(posedge lclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      link_sts.phy_err <= 1'b0;
    end
    else
    begin
      link_sts.phy_err <= align_err;
    end
  end

  assign tx_online = link_sts.link_up;
  assign rx_online = link_sts.link_up;

endmodule

// File: txrx/lpif_rx.sv
/*
 * Upstream path. Picks the far-side word or, in loopback, the local
 * transmit word, and registers it onto the LPIF receive ports. No
 * back-pressure, so words arriving while the link is down are dropped.
 */

`timescale 1ns/10ps

module lpif_rx (
  input  logic                 lclk,
  input  logic                 arst_n,
  input  logic                 rx_enable,
  input  logic                 lpbk_en,
  input  lpif_pkg::aib_word_t  dout,
  input  lpif_pkg::aib_word_t  tx_word,
  output logic                 pl_valid,
  output lpif_pkg::lpif_flit_t pl_flit
);

  lpif_pkg::aib_word_t src_word;
  logic                src_take;

  // Loopback select
  assign src_word = lpbk_en ? tx_word : dout;
  assign src_take = src_word.valid & rx_enable;

  always_ff @(posedge lclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pl_valid <= 1'b0;
    end
    else
    begin
      pl_valid <= src_take;
    end
  end

  // Flit holds between valid words
  always_ff @(posedge lclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pl_flit <= '0;
    end
    else if (src_take)
    begin
      pl_flit <= src_word.flit;
    end
  end

endmodule

// File: txrx/lpif_tx.sv
/*
 * Downstream path. Accepts flits from the link layer on the LPIF
 * handshake into a small circular FIFO and drains one flit per cycle
 * into the registered AIB word on data_in_f while enabled.
 */

`timescale 1ns/10ps

module lpif_tx (
  input  logic                 lclk,
  input  logic                 arst_n,
  input  logic                 tx_enable,
  input  logic                 lp_irdy,
  input  logic                 lp_valid,
  input  lpif_pkg::lpif_flit_t lp_flit,
  output logic                 pl_trdy,
  output lpif_pkg::aib_word_t  data_in_f
);

  lpif_pkg::lpif_flit_t              fifo_mem [lpif_pkg::TX_FIFO_DEPTH];
  logic [lpif_pkg::TX_PTR_WIDTH-1:0] wr_ptr;
  logic [lpif_pkg::TX_PTR_WIDTH-1:0] rd_ptr;
  logic [lpif_pkg::TX_CNT_WIDTH-1:0] count;
  logic                              push;
  logic                              pop;

  assign pl_trdy = (count != lpif_pkg::TX_CNT_FULL) & tx_enable;
  assign push    = lp_irdy & lp_valid & pl_trdy;
  assign pop     = tx_enable & (count != '0);

  ////////////////////////////////////////////////////////////
  // Flit buffer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge lclk)
  begin
    if (push)
    begin
      fifo_mem[wr_ptr] <= lp_flit;
    end
  end

  always_ff @(posedge lclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= (wr_ptr == lpif_pkg::TX_PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= (rd_ptr == lpif_pkg::TX_PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or push and pop together
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // AIB word packing
  ////////////////////////////////////////////////////////////

  always_ff @(posedge lclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      data_in_f <= '0;
    end
    else if (pop)
    begin
      data_in_f.valid <= 1'b1;
      data_in_f.rsvd  <= '0;
      data_in_f.flit  <= fifo_mem[rd_ptr];  // Oldest flit
    end
    else
    begin
      data_in_f <= '0;  // Idle word
    end
  end

endmodule

// File: verification/lpif_checker.sv
/*
 * Testbench checker for the LPIF-to-AIB adapter. Watches every DUT port,
 * keeps a reference model of link control, the LPIF state machine, the
 * transmit FIFO and the receive register, and compares at each clock edge.
 */

`timescale 1ns/10ps

module lpif_checker (
  input  logic                                   lclk,
  input  logic                                   arst_n,
  input  logic                                   lp_irdy,
  input  logic                                   lp_valid,
  input  logic [lpif_pkg::LPIF_DATA_BYTES*8-1:0] lp_data,
  input  logic [lpif_pkg::STREAM_WIDTH-1:0]      lp_stream,
  input  logic                                   pl_trdy,
  input  logic                                   pl_valid,
  input  logic [lpif_pkg::LPIF_DATA_BYTES*8-1:0] pl_data,
  input  logic [lpif_pkg::STREAM_WIDTH-1:0]      pl_stream,
  input  lpif_pkg::lpif_state_e                  lp_state_req,
  input  logic                                   lp_linkerror,
  input  lpif_pkg::lpif_state_e                  pl_state_sts,
  input  logic                                   pl_lnk_up,
  input  logic                                   i_conf_done,
  input  logic                                   fs_mac_rdy,
  input  logic [lpif_pkg::AIB_LANES-1:0]         tx_transfer_en,
  input  logic [lpif_pkg::AIB_LANES-1:0]         rx_transfer_en,
  input  logic                                   align_done,
  input  logic                                   align_err,
  input  lpif_pkg::aib_word_t                    dout,
  input  logic                                   lpbk_en,
  input  logic                                   ns_mac_rdy,
  input  logic                                   tx_online,
  input  logic                                   rx_online,
  input  lpif_pkg::aib_word_t                    data_in_f,
  output int                                     err_count,
  output int                                     check_count
);

  int                    errors = 0;
  int                    checks = 0;
  logic                  mac_rdy_m;
  int                    settle_m;
  logic                  link_up_m;
  logic                  phy_err_m;
  lpif_pkg::lpif_state_e state_m;
  lpif_pkg::lpif_flit_t  tx_q[$];     // Accepted, not yet sent
  lpif_pkg::aib_word_t   din_m;
  logic                  pl_valid_m;
  lpif_pkg::lpif_flit_t  pl_flit_m;
  lpif_pkg::aib_word_t   src_m;
  lpif_pkg::lpif_flit_t  in_flit_m;
  logic                  lnk_m;
  logic                  good_m;
  logic                  push_m;
  logic                  pop_m;

  assign err_count   = errors;
  assign check_count = checks;

  function automatic logic trdy_model();
    return (tx_q.size() < lpif_pkg::TX_FIFO_DEPTH) && (state_m == lpif_pkg::ST_ACTIVE);
  endfunction

  task compare_value(input string name, input logic [lpif_pkg::AIB_WIDTH-1:0] exp,
                     input logic [lpif_pkg::AIB_WIDTH-1:0] got);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, got);
    end
  endtask

  task reset_model();
    mac_rdy_m  = 1'b0;
    settle_m   = 0;
    link_up_m  = 1'b0;
    phy_err_m  = 1'b0;
    state_m    = lpif_pkg::ST_RESET;
    tx_q.delete();
    din_m      = '0;
    pl_valid_m = 1'b0;
    pl_flit_m  = '0;
  endtask

  //////////////////////////////////////////////////////////////
  // Output comparison, values as they stood before this edge
  //////////////////////////////////////////////////////////////

  task check_outputs();
    compare_value("pl_state_sts", state_m, pl_state_sts);
    compare_value("pl_lnk_up", state_m == lpif_pkg::ST_ACTIVE, pl_lnk_up);
    compare_value("pl_trdy", trdy_model(), pl_trdy);
    compare_value("ns_mac_rdy", mac_rdy_m, ns_mac_rdy);
    compare_value("tx_online", link_up_m, tx_online);
    compare_value("rx_online", link_up_m, rx_online);
    if (data_in_f.valid === 1'b1 && !din_m.valid)
    begin
      checks++;
      errors++;
      $display("At %0t ns data_in_f carries a valid word while no flit is pending", $time);
    end
    else
    begin
      compare_value("data_in_f", din_m, data_in_f);
    end
    compare_value("pl_valid", pl_valid_m, pl_valid);
    compare_value("pl_data", pl_flit_m.data, pl_data);
    compare_value("pl_stream", pl_flit_m.stream, pl_stream);
  endtask

  //////////////////////////////////////////////////////////////
  // Reference model step
  //////////////////////////////////////////////////////////////

  task step_model();
    lnk_m  = (state_m == lpif_pkg::ST_ACTIVE);
    good_m = mac_rdy_m && fs_mac_rdy && (&tx_transfer_en) && (&rx_transfer_en) && align_done;

    src_m      = lpbk_en ? din_m : dout;  // Loopback sees the previous tx word
    pl_valid_m = src_m.valid && lnk_m;
    if (pl_valid_m)
    begin
      pl_flit_m = src_m.flit;
    end

    push_m = lp_irdy && lp_valid && trdy_model();
    pop_m  = lnk_m && (tx_q.size() != 0);
    din_m  = '0;
    if (pop_m)
    begin
      din_m.valid = 1'b1;
      din_m.flit  = tx_q.pop_front();
    end
    if (push_m)
    begin
      in_flit_m.stream = lp_stream;
      in_flit_m.data   = lp_data;
      tx_q.push_back(in_flit_m);
    end

    case (state_m)
      lpif_pkg::ST_RESET,
      lpif_pkg::ST_RETRAIN:
      begin
        if (link_up_m && lp_state_req == lpif_pkg::ST_ACTIVE)
        begin
          state_m = lpif_pkg::ST_ACTIVE;
        end
      end
      lpif_pkg::ST_ACTIVE:
      begin
        if (phy_err_m || lp_linkerror)
        begin
          state_m = lpif_pkg::ST_LINKERROR;
        end
        else if (!link_up_m || lp_state_req == lpif_pkg::ST_RETRAIN)
        begin
          state_m = lpif_pkg::ST_RETRAIN;
        end
      end
      lpif_pkg::ST_LINKERROR:
      begin
        if (lp_state_req == lpif_pkg::ST_RESET)
        begin
          state_m = lpif_pkg::ST_RESET;
        end
      end
      default:
      begin
        state_m = lpif_pkg::ST_RESET;
      end
    endcase

    // Settle run of good cycles
    if (!good_m)
    begin
      settle_m  = 0;
      link_up_m = 1'b0;
    end
    else
    begin
      settle_m  = (settle_m < lpif_pkg::LINK_SETTLE_CYCLES) ? settle_m + 1 : settle_m;
      link_up_m = link_up_m || (settle_m == lpif_pkg::LINK_SETTLE_CYCLES);
    end
    phy_err_m = align_err;
    mac_rdy_m = mac_rdy_m || i_conf_done;
  endtask

  always @(posedge lclk)
  begin
    if (!arst_n)
    begin
      reset_model();
    end
    else
    begin
      check_outputs();
      step_model();
    end
  end

endmodule

// File: verification/tb_lpif_adapter.sv
/*
 * Testbench for the LPIF-to-AIB adapter. Runs reset, bring-up, downstream,
 * upstream, loopback and link loss tests with seeded random traffic, while
 * lpif_checker compares every DUT output against its model.
 */

`timescale 1ns/10ps

module tb_lpif_adapter;

  localparam int CLK_PERIOD     = 4;
  localparam int RESET_CYCLES   = 5;
  localparam int SEED           = 32'hbdb4_d2a6;
  localparam int IDLE_CYCLES    = 10;
  localparam int TRAFFIC_CYCLES = 200;
  localparam int WAIT_LIMIT     = 40;   // Cycles allowed for one state change
  localparam int BUDGET_CYCLES  = RESET_CYCLES + 3 * TRAFFIC_CYCLES + 10 * IDLE_CYCLES +
                                  10 * WAIT_LIMIT + 100;
  localparam int WATCHDOG_NS    = (BUDGET_CYCLES + 100) * CLK_PERIOD;

  logic                                   lclk = 1'b0;
  logic                                   arst_n;
  logic                                   lp_irdy;
  logic                                   lp_valid;
  logic [lpif_pkg::LPIF_DATA_BYTES*8-1:0] lp_data;
  logic [lpif_pkg::STREAM_WIDTH-1:0]      lp_stream;
  logic                                   pl_trdy;
  logic                                   pl_valid;
  logic [lpif_pkg::LPIF_DATA_BYTES*8-1:0] pl_data;
  logic [lpif_pkg::STREAM_WIDTH-1:0]      pl_stream;
  lpif_pkg::lpif_state_e                  lp_state_req;
  logic                                   lp_linkerror;
  lpif_pkg::lpif_state_e                  pl_state_sts;
  logic                                   pl_lnk_up;
  logic                                   i_conf_done;
  logic                                   fs_mac_rdy;
  logic [lpif_pkg::AIB_LANES-1:0]         tx_transfer_en;
  logic [lpif_pkg::AIB_LANES-1:0]         rx_transfer_en;
  logic                                   align_done;
  logic                                   align_err;
  lpif_pkg::aib_word_t                    dout;
  logic                                   lpbk_en;
  logic                                   ns_mac_rdy;
  logic                                   tx_online;
  logic                                   rx_online;
  lpif_pkg::aib_word_t                    data_in_f;
  int                                     err_count;
  int                                     check_count;
  int                                     tb_errors = 0;
  int                                     test_num = 0;
  int                                     errors_at_start;

  always #(CLK_PERIOD / 2) lclk = ~lclk;

  lpif_adapter DUT (.*);

  lpif_checker u_checker (.*);

  function automatic int total_errors();
    return err_count + tb_errors;
  endfunction

  //////////////////////////////////////////////////////////////
  // Stimulus helpers called right after a rising edge
  //////////////////////////////////////////////////////////////

  task automatic drive_idle();
    lp_irdy  <= 1'b0;
    lp_valid <= 1'b0;
    dout     <= '0;
  endtask

  task automatic drive_random(input int irdy_pct, input int dout_pct);
    lpif_pkg::aib_word_t word;
    word.valid       = ($urandom % 100) < dout_pct;
    word.rsvd        = '0;
    word.flit.stream = $urandom;
    word.flit.data   = {$urandom, $urandom};
    lp_irdy   <= ($urandom % 100) < irdy_pct;   // Gaps between flits
    lp_valid  <= ($urandom % 100) < 90;
    lp_data   <= {$urandom, $urandom};
    lp_stream <= $urandom;
    dout      <= word;
  endtask

  task automatic run_traffic(input int cycles, input int irdy_pct, input int dout_pct);
    repeat (cycles)
    begin
      @(posedge lclk);
      drive_random(irdy_pct, dout_pct);
    end
  endtask

  task automatic idle_cycles(input int cycles);
    repeat (cycles)
    begin
      @(posedge lclk);
      drive_idle();
    end
  endtask

  task automatic set_link_inputs(input logic on);
    fs_mac_rdy     <= on;
    tx_transfer_en <= {lpif_pkg::AIB_LANES{on}};
    rx_transfer_en <= {lpif_pkg::AIB_LANES{on}};
    align_done     <= on;
  endtask

  task automatic wait_for_state(input lpif_pkg::lpif_state_e target);
    int n;
    n = 0;
    while (pl_state_sts !== target && n < WAIT_LIMIT)
    begin
      @(posedge lclk);
      drive_idle();
      n++;
    end
    if (pl_state_sts !== target)
    begin
      tb_errors++;
      $display("At %0t ns the link did not reach %s within %0d cycles", $time,
               target.name(), WAIT_LIMIT);
    end
  endtask

  task automatic begin_test();
    test_num++;
    errors_at_start = total_errors();
  endtask

  task automatic end_test(input string name);
    $display("test %0d %-10s : %0d errors", test_num, name, total_errors() - errors_at_start);
  endtask

  //////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////

  initial
  begin
    void'($urandom(SEED));
    arst_n         = 1'b0;
    lp_irdy        = 1'b0;
    lp_valid       = 1'b0;
    lp_data        = '0;
    lp_stream      = '0;
    lp_state_req   = lpif_pkg::ST_RESET;
    lp_linkerror   = 1'b0;
    i_conf_done    = 1'b0;
    fs_mac_rdy     = 1'b0;
    tx_transfer_en = '0;
    rx_transfer_en = '0;
    align_done     = 1'b0;
    align_err      = 1'b0;
    dout           = '0;
    lpbk_en        = 1'b0;
    repeat (RESET_CYCLES) @(posedge lclk);
    arst_n <= 1'b1;

    begin_test();
    idle_cycles(IDLE_CYCLES);
    end_test("reset");

    begin_test();
    @(posedge lclk);
    i_conf_done  <= 1'b1;
    lp_state_req <= lpif_pkg::ST_ACTIVE;
    set_link_inputs(1'b1);
    @(posedge lclk);
    i_conf_done <= 1'b0;  // MAC ready stays set after one pulse
    idle_cycles(3);
    @(posedge lclk);
    align_done <= 1'b0;   // Short break restarts the settle count
    @(posedge lclk);
    align_done <= 1'b1;
    idle_cycles(lpif_pkg::LINK_SETTLE_CYCLES - 2);
    wait_for_state(lpif_pkg::ST_ACTIVE);
    end_test("bring_up");

    begin_test();
    run_traffic(TRAFFIC_CYCLES, 70, 0);
    idle_cycles(IDLE_CYCLES);
    end_test("downstream");

    begin_test();
    run_traffic(TRAFFIC_CYCLES, 0, 60);
    idle_cycles(IDLE_CYCLES);
    end_test("upstream");

    begin_test();
    @(posedge lclk);
    lpbk_en <= 1'b1;
    run_traffic(TRAFFIC_CYCLES, 70, 60);
    idle_cycles(IDLE_CYCLES);
    @(posedge lclk);
    lpbk_en <= 1'b0;
    end_test("loopback");

    begin_test();
    run_traffic(20, 100, 50);
    @(posedge lclk);
    tx_transfer_en[0] <= 1'b0;
    drive_random(100, 50);
    run_traffic(6, 100, 50);
    wait_for_state(lpif_pkg::ST_RETRAIN);
    run_traffic(5, 100, 50);              // Held off while retraining
    @(posedge lclk);
    tx_transfer_en[0] <= 1'b1;
    drive_idle();
    wait_for_state(lpif_pkg::ST_ACTIVE);
    idle_cycles(IDLE_CYCLES);
    @(posedge lclk);
    align_err <= 1'b1;
    @(posedge lclk);
    align_err <= 1'b0;
    wait_for_state(lpif_pkg::ST_LINKERROR);
    idle_cycles(IDLE_CYCLES);             // LinkError holds with Active requested
    @(posedge lclk);
    lp_state_req <= lpif_pkg::ST_RESET;
    wait_for_state(lpif_pkg::ST_RESET);
    idle_cycles(IDLE_CYCLES);
    @(posedge lclk);
    lp_state_req <= lpif_pkg::ST_ACTIVE;
    wait_for_state(lpif_pkg::ST_ACTIVE);
    @(posedge lclk);
    lp_state_req <= lpif_pkg::ST_RETRAIN; // Link layer asks for retrain
    wait_for_state(lpif_pkg::ST_RETRAIN);
    @(posedge lclk);
    lp_state_req <= lpif_pkg::ST_ACTIVE;
    wait_for_state(lpif_pkg::ST_ACTIVE);
    @(posedge lclk);
    lp_linkerror <= 1'b1;                 // Link layer reports an error
    @(posedge lclk);
    lp_linkerror <= 1'b0;
    wait_for_state(lpif_pkg::ST_LINKERROR);
    @(posedge lclk);
    lp_state_req <= lpif_pkg::ST_RESET;
    wait_for_state(lpif_pkg::ST_RESET);
    end_test("link_loss");

    $display("tests %0d, checks %0d, errors %0d", test_num, check_count, total_errors());
    if (total_errors() == 0)
    begin
      $display(">>> PASS");
    end
    else
    begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before the tests completed", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
  end

endmodule
